//--- src/snes_cfg.svh
`ifndef SNES_CFG_SVH
`define SNES_CFG_SVH

// number of controller ports
`define SNES_NUM_PORTS 2

// latch high time and post-frame tail, 12 us at 50 MHz
`define SNES_LATCH_CYCLES 600

// serial clock low time and high time, 6 us each
`define SNES_HALF_CYCLES 300

// serial bits clocked per frame
`define SNES_FRAME_BITS 16

// poll period, must be longer than one whole frame
`define SNES_POLL_CYCLES 12000

`endif

//--- src/snes_pkg.sv
package snes_pkg;

	// button word in the preferred order, msb first
	// sel x bl br | start y a b | right left down up
	typedef struct packed {
		logic sel;
		logic x;
		logic bl;
		logic br;
		logic start;
		logic y;
		logic a;
		logic b;
		logic right;
		logic left;
		logic down;
		logic up;
	} pad_buttons_t;

	// one entry on the shared register-file write port
	typedef struct packed {
		logic         port;
		pad_buttons_t buttons;
	} pad_write_t;

	// what the host sees for one port
	typedef struct packed {
		logic         changed;
		pad_buttons_t buttons;
	} pad_status_t;

endpackage

//--- src/snes_poll_timer.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module snes_poll_timer
(
	input  logic clk_50,
	input  logic arst_n,
	input  logic enable,
	input  logic pads_idle,
	output logic start
);

	localparam int CNT_W = $clog2(`SNES_POLL_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SNES_POLL_CYCLES - 1);

	logic [CNT_W-1:0] cnt_q;
	logic             period_end;

	assign period_end = enable && (cnt_q == CNT_LAST);

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt_q <= '0;
			start <= 1'b0;
		end
		else
		begin
			// counter restarts while disabled
			if (!enable || period_end)
				cnt_q <= '0;
			else
				cnt_q <= cnt_q + 1'b1;
			// skip this period if a reader is still busy
			start <= period_end && pads_idle;
		end
	end

endmodule

//--- src/snes_pad_reader.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module snes_pad_reader
#(
	parameter int PORT = 0
)
(
	input  logic                 clk_50,
	input  logic                 arst_n,
	input  logic                 start,
	input  logic                 data_in_snes,
	input  logic                 wr_gnt,
	output logic                 latch_snes,
	output logic                 clk_snes,
	output logic                 idle,
	output logic                 wr_req,
	output snes_pkg::pad_write_t wr_data
);

	localparam int DLY_W     = $clog2(`SNES_LATCH_CYCLES);
	localparam int BIT_W     = $clog2(`SNES_FRAME_BITS);
	localparam int KEEP_BITS = $bits(snes_pkg::pad_buttons_t);

	// one-hot state bit positions
	localparam int ST_IDLE   = 0;
	localparam int ST_LATCH  = 1;
	localparam int ST_CLK_LO = 2;
	localparam int ST_CLK_HI = 3;
	localparam int ST_TAIL   = 4;
	localparam int ST_WAIT   = 5;

	localparam logic [DLY_W-1:0] LATCH_LOAD = DLY_W'(`SNES_LATCH_CYCLES - 1);
	localparam logic [DLY_W-1:0] HALF_LOAD  = DLY_W'(`SNES_HALF_CYCLES - 1);
	localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(`SNES_FRAME_BITS - 1);

	logic [5:0]           state_q;
	logic [DLY_W-1:0]     dly_q;
	logic [BIT_W-1:0]     bit_q;
	logic [KEEP_BITS-1:0] sh_q;
	logic                 dly_done;
	logic                 fall_cycle;
	snes_pkg::pad_buttons_t btn;

	assign dly_done = (dly_q == '0);

	// first cycle with the serial clock low
	assign fall_cycle = state_q[ST_CLK_LO] && (dly_q == HALF_LOAD);

	// pins and handshake straight from the state bits
	assign latch_snes = state_q[ST_LATCH];
	assign clk_snes   = ~state_q[ST_CLK_LO];
	assign idle       = state_q[ST_IDLE];
	assign wr_req     = state_q[ST_WAIT];

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q <= 6'(1) << ST_IDLE;
			dly_q   <= '0;
			bit_q   <= '0;
		end
		else
		begin
			case (1'b1)
				state_q[ST_IDLE]:
				begin
					bit_q <= '0;
					if (start)
					begin
						state_q <= 6'(1) << ST_LATCH;
						dly_q   <= LATCH_LOAD;
					end
				end
				state_q[ST_LATCH]:
				begin
					dly_q <= dly_q - 1'b1;
					if (dly_done)
					begin
						state_q <= 6'(1) << ST_CLK_LO;
						dly_q   <= HALF_LOAD;
					end
				end
				state_q[ST_CLK_LO]:
				begin
					dly_q <= dly_q - 1'b1;
					if (dly_done)
					begin
						state_q <= 6'(1) << ST_CLK_HI;
						dly_q   <= HALF_LOAD;
					end
				end
				state_q[ST_CLK_HI]:
				begin
					dly_q <= dly_q - 1'b1;
					if (dly_done)
					begin
						if (bit_q == LAST_BIT)
						begin
							state_q <= 6'(1) << ST_TAIL;
							dly_q   <= LATCH_LOAD;
							bit_q   <= '0;
						end
						else
						begin
							state_q <= 6'(1) << ST_CLK_LO;
							dly_q   <= HALF_LOAD;
							bit_q   <= bit_q + 1'b1;
						end
					end
				end
				state_q[ST_TAIL]:
				begin
					dly_q <= dly_q - 1'b1;
					if (dly_done)
					begin
						state_q <= 6'(1) << ST_WAIT;
					end
				end
				state_q[ST_WAIT]:
				begin
					// hold the request until the arbiter takes it
					if (wr_gnt)
					begin
						state_q <= 6'(1) << ST_IDLE;
					end
				end
				default:
				begin
					state_q <= 6'(1) << ST_IDLE;
					dly_q   <= '0;
					bit_q   <= '0;
				end
			endcase
		end
	end

	// shift in lsb first, the trailing four bits are not kept
	always_ff @(posedge clk_50)
	begin
		if (fall_cycle && (bit_q < BIT_W'(KEEP_BITS)))
		begin
			sh_q <= {data_in_snes, sh_q[KEEP_BITS-1:1]};
		end
	end

	// wire order b y sel start up down left right a x bl br
	always_comb
	begin
		btn.b     = sh_q[0];
		btn.y     = sh_q[1];
		btn.sel   = sh_q[2];
		btn.start = sh_q[3];
		btn.up    = sh_q[4];
		btn.down  = sh_q[5];
		btn.left  = sh_q[6];
		btn.right = sh_q[7];
		btn.a     = sh_q[8];
		btn.x     = sh_q[9];
		btn.bl    = sh_q[10];
		btn.br    = sh_q[11];
	end

	// shift register is frozen from the tail on, so this stays steady
	assign wr_data.port    = 1'(PORT);
	assign wr_data.buttons = btn;

endmodule

//--- src/pad_write_arbiter.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module pad_write_arbiter
(
	input  logic                        clk_50,
	input  logic                        arst_n,
	input  logic [`SNES_NUM_PORTS-1:0]  req,
	input  snes_pkg::pad_write_t        req_data [`SNES_NUM_PORTS],
	output logic [`SNES_NUM_PORTS-1:0]  gnt,
	output logic                        wr_en,
	output snes_pkg::pad_write_t        wr_data
);

	// port that won the last grant
	logic last_q;

	always_comb
	begin
		gnt = req;
		// on contention favour the one not served last
		if (req[0] && req[1])
		begin
			if (last_q)
				gnt = 2'b01;
			else
				gnt = 2'b10;
		end
	end

	assign wr_en   = |gnt;
	assign wr_data = gnt[1] ? req_data[1] : req_data[0];

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// port 0 goes first after reset
			last_q <= 1'b1;
		end
		else if (wr_en)
		begin
			last_q <= gnt[1];
		end
	end

endmodule

//--- src/pad_state_regs.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module pad_state_regs
(
	input  logic                  clk_50,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  snes_pkg::pad_write_t  wr_data,
	input  logic                  rd_port,
	input  logic                  rd_strobe,
	output snes_pkg::pad_status_t rd_data,
	output logic                  upd_valid,
	output logic                  upd_port
);

	snes_pkg::pad_buttons_t           btn_q [`SNES_NUM_PORTS];
	logic [`SNES_NUM_PORTS-1:0]       chg_q;

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int p = 0; p < `SNES_NUM_PORTS; p++)
			begin
				btn_q[p] <= '0;
			end
			chg_q     <= '0;
			upd_valid <= 1'b0;
			upd_port  <= 1'b0;
		end
		else
		begin
			for (int p = 0; p < `SNES_NUM_PORTS; p++)
			begin
				if (wr_en && (wr_data.port == 1'(p)))
				begin
					// write beats a same-cycle read strobe
					btn_q[p] <= wr_data.buttons;
					if (wr_data.buttons != btn_q[p])
						chg_q[p] <= 1'b1;
				end
				else if (rd_strobe && (rd_port == 1'(p)))
				begin
					chg_q[p] <= 1'b0;
				end
			end
			upd_valid <= wr_en;
			if (wr_en)
				upd_port <= wr_data.port;
		end
	end

	// host read, no register in the path
	assign rd_data.changed = chg_q[rd_port];
	assign rd_data.buttons = btn_q[rd_port];

endmodule

//--- src/snes_input_top.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module snes_input_top
(
	input  logic                        clk_50,
	input  logic                        arst_n,
	input  logic                        poll_en,
	input  logic [`SNES_NUM_PORTS-1:0]  data_in_snes,
	input  logic                        rd_port,
	input  logic                        rd_strobe,
	output logic [`SNES_NUM_PORTS-1:0]  latch_snes,
	output logic [`SNES_NUM_PORTS-1:0]  clk_snes,
	output snes_pkg::pad_status_t       rd_data,
	output logic                        upd_valid,
	output logic                        upd_port
);

	logic                       start;
	logic [`SNES_NUM_PORTS-1:0] pad_idle;
	logic [`SNES_NUM_PORTS-1:0] wr_req;
	logic [`SNES_NUM_PORTS-1:0] wr_gnt;
	snes_pkg::pad_write_t       req_data [`SNES_NUM_PORTS];
	logic                       wr_en;
	snes_pkg::pad_write_t       wr_data;

	// no new frame until every reader is back in idle
	wire pads_idle = &pad_idle;

	snes_poll_timer u_poll_timer
	(
		.clk_50    (clk_50),
		.arst_n    (arst_n),
		.enable    (poll_en),
		.pads_idle (pads_idle),
		.start     (start)
	);

	for (genvar i = 0; i < `SNES_NUM_PORTS; i++)
	begin : g_reader
		snes_pad_reader #(.PORT(i)) u_reader
		(
			.clk_50       (clk_50),
			.arst_n       (arst_n),
			.start        (start),
			.data_in_snes (data_in_snes[i]),
			.wr_gnt       (wr_gnt[i]),
			.latch_snes   (latch_snes[i]),
			.clk_snes     (clk_snes[i]),
			.idle         (pad_idle[i]),
			.wr_req       (wr_req[i]),
			.wr_data      (req_data[i])
		);
	end

	pad_write_arbiter u_arbiter
	(
		.clk_50   (clk_50),
		.arst_n   (arst_n),
		.req      (wr_req),
		.req_data (req_data),
		.gnt      (wr_gnt),
		.wr_en    (wr_en),
		.wr_data  (wr_data)
	);

	pad_state_regs u_state_regs
	(
		.clk_50    (clk_50),
		.arst_n    (arst_n),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.rd_port   (rd_port),
		.rd_strobe (rd_strobe),
		.rd_data   (rd_data),
		.upd_valid (upd_valid),
		.upd_port  (upd_port)
	);

endmodule

//--- tests/tb_snes_input_top.sv
`timescale 1ns/10ps
`include "snes_cfg.svh"

module tb_snes_input_top;

	localparam int NUM_FRAMES     = 3;
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = 6 * `SNES_POLL_CYCLES + RESET_CYCLES;

	logic                   clk_50 = 1'b0;
	logic                   arst_n;
	logic                   poll_en;
	logic [1:0]             data_in_snes = 2'b11;
	logic                   rd_port;
	logic                   rd_strobe;
	logic [1:0]             latch_snes;
	logic [1:0]             clk_snes;
	snes_pkg::pad_status_t  rd_data;
	logic                   upd_valid;
	logic                   upd_port;

	logic [31:0]            rng = 32'hcb83;
	logic [15:0]            frame_word [2];
	logic [15:0]            ctl_sh [2];
	snes_pkg::pad_buttons_t exp_btn [2];
	logic [1:0]             exp_chg;
	logic [1:0]             clk_prev = 2'b11;
	logic [1:0]             latch_prev = 2'b00;
	int                     latch_len [2] = '{0, 0};
	int                     fall_cnt [2] = '{0, 0};
	int                     latch_rises = 0;
	int                     upd_total = 0;
	int                     cycle_cnt = 0;
	int                     value_errors = 0;
	int                     event_errors = 0;

	snes_input_top DUT (.*);

	always #2 clk_50 = ~clk_50;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// wire order b y sel start up down left right a x bl br
	function automatic snes_pkg::pad_buttons_t remap_word(input logic [15:0] w);
		snes_pkg::pad_buttons_t r;
		r.b     = w[0];
		r.y     = w[1];
		r.sel   = w[2];
		r.start = w[3];
		r.up    = w[4];
		r.down  = w[5];
		r.left  = w[6];
		r.right = w[7];
		r.a     = w[8];
		r.x     = w[9];
		r.bl    = w[10];
		r.br    = w[11];
		return r;
	endfunction

	task automatic check_buttons(input string name, input snes_pkg::pad_buttons_t exp,
		input snes_pkg::pad_buttons_t act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_status(input string name, input snes_pkg::pad_status_t exp,
		input snes_pkg::pad_status_t act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	// host read is combinational so sample one edge after setting the port
	task automatic read_port(input logic p, output snes_pkg::pad_status_t s);
		@(posedge clk_50);
		rd_port <= p;
		@(posedge clk_50);
		s = rd_data;
	endtask

	task automatic strobe_port(input logic p);
		@(posedge clk_50);
		rd_port   <= p;
		rd_strobe <= 1'b1;
		@(posedge clk_50);
		rd_strobe <= 1'b0;
	endtask

	// controller model and pin monitor for both ports
	always @(posedge clk_50)
	begin
		for (int p = 0; p < 2; p++)
		begin
			if (latch_snes[p])
			begin
				// word loads while latch is high and bit 0 goes on the wire
				ctl_sh[p]       <= frame_word[p];
				data_in_snes[p] <= frame_word[p][0];
				latch_len[p]    <= latch_len[p] + 1;
				fall_cnt[p]     <= 0;
			end
			else
			begin
				if (latch_prev[p])
				begin
					check_count($sformatf("latch length port %0d", p),
						`SNES_LATCH_CYCLES, latch_len[p]);
					latch_len[p] <= 0;
				end
				// next bit after each rising serial clock
				if (clk_snes[p] && !clk_prev[p])
				begin
					ctl_sh[p]       <= ctl_sh[p] >> 1;
					data_in_snes[p] <= ctl_sh[p][1];
				end
			end
			if (!clk_snes[p] && clk_prev[p])
				fall_cnt[p] <= fall_cnt[p] + 1;
		end
		if (|(latch_snes & ~latch_prev))
			latch_rises <= latch_rises + 1;
		if (upd_valid)
			upd_total <= upd_total + 1;
		latch_prev <= latch_snes;
		clk_prev   <= clk_snes;
	end

	always @(posedge clk_50)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value, %0d event", value_errors, event_errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		snes_pkg::pad_status_t s;
		logic [1:0]            seen;
		logic                  p;
		int                    rises;
		int                    updates;

		arst_n     = 1'b0;
		poll_en    = 1'b0;
		rd_port    = 1'b0;
		rd_strobe  = 1'b0;
		exp_chg    = '0;
		exp_btn    = '{default: '0};
		frame_word = '{default: '0};
		repeat (RESET_CYCLES) @(posedge clk_50);
		arst_n <= 1'b1;
		@(posedge clk_50);

		check_count("reset latch", 0, latch_snes);
		check_count("reset serial clock", 3, clk_snes);
		check_count("reset upd_valid", 0, upd_valid);
		for (int i = 0; i < 2; i++)
		begin
			read_port(i[0], s);
			check_buttons($sformatf("reset buttons port %0d", i), '0, s.buttons);
			check_count($sformatf("reset changed port %0d", i), 0, s.changed);
		end

		poll_en <= 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			// ports take turns repeating their last word
			for (int i = 0; i < 2; i++)
			begin
				if (f == 0 || ((f + i) % 2 == 0))
				begin
					rng           = xorshift(rng);
					frame_word[i] = rng[15:0];
				end
			end
			// watch one entry while the two updates land
			rd_port <= f[0];
			seen = 2'b00;
			while (seen != 2'b11)
			begin
				@(posedge clk_50);
				if (upd_valid)
				begin
					p = upd_port;
					if (seen[p])
					begin
						$display("frame %0d: port %0d sent a second update", f, p);
						event_errors++;
					end
					seen[p] = 1'b1;
					check_count($sformatf("frame %0d port %0d clock falls", f, p),
						`SNES_FRAME_BITS, fall_cnt[p]);
					if (remap_word(frame_word[p]) != exp_btn[p])
						exp_chg[p] = 1'b1;
					exp_btn[p] = remap_word(frame_word[p]);
					// entry and pulse change in the same cycle
					check_status($sformatf("frame %0d update port %0d", f, p),
						{exp_chg[f % 2], exp_btn[f % 2]}, rd_data);
				end
			end
			for (int i = 0; i < 2; i++)
			begin
				read_port(i[0], s);
				check_status($sformatf("frame %0d port %0d", f, i), {exp_chg[i], exp_btn[i]}, s);
			end
			// clear one port while the other keeps its flag into the next frame
			strobe_port(f[0]);
			exp_chg[f % 2] = 1'b0;
			for (int i = 0; i < 2; i++)
			begin
				read_port(i[0], s);
				check_status($sformatf("frame %0d port %0d strobed", f, i),
					{exp_chg[i], exp_btn[i]}, s);
			end
		end
		check_count("latch pulses", NUM_FRAMES, latch_rises);
		check_count("update pulses", 2 * NUM_FRAMES, upd_total);

		// a full poll period with polling off
		poll_en <= 1'b0;
		rises   = latch_rises;
		updates = upd_total;
		repeat (`SNES_POLL_CYCLES + 100) @(posedge clk_50);
		check_count("latch pulses while disabled", rises, latch_rises);
		check_count("updates while disabled", updates, upd_total);

		$display("errors: %0d value, %0d event", value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- snes_input_top.f
+incdir+src
src/snes_pkg.sv
src/snes_poll_timer.sv
src/snes_pad_reader.sv
src/pad_write_arbiter.sv
src/pad_state_regs.sv
src/snes_input_top.sv
tests/tb_snes_input_top.sv

//--- Makefile
TOP = tb_snes_input_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f snes_input_top.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
